/* Bender.yml */
package:
  name: cpu_wrapper

sources:
  - src/cpu_pkg.sv
  - src/cpu_decode.sv
  - src/cpu_alu.sv
  - src/cpu_regs.sv
  - src/cpu_core.sv
  - src/cpu_wrapper.sv
  - target: simulation
    files:
      - sim/cpu_wrapper_asserts.sv
      - sim/tb_cpu_wrapper.sv

/* sim/cpu_wrapper_asserts.sv */
`timescale 1ns/1ps

module cpu_wrapper_asserts import cpu_pkg::*; (
   input logic              clk,
   input logic              reset,                 // sync, active high
   input logic              rdy_in,                // combined ready, falling edge
   input logic              res,                   // vector fetch in progress
   input logic              rd,                    // low on accepted write
   input logic [ADDR_W-1:0] ab,                    // address bus
   input logic [DATA_W-1:0] db_out                 // store data
);

   // stalled cycle freezes the core, ab and store data hold one more cycle
   a_stall_hold: assert property (@(posedge clk) disable iff (reset)
                                  !rdy_in |=> $stable(ab) && $stable(db_out))
      else $error("ab or db_out moved after a stalled cycle");

   // a store writes once, the next cycle is an opcode fetch
   a_one_write: assert property (@(posedge clk) disable iff (reset) !rd |=> rd)
      else $error("rd low in two cycles in a row");

   // first cycle out of reset reads the vector low byte
   a_reset_vec: assert property (@(posedge clk) $fell(reset) |-> (ab == RESET_VEC) && res)
      else $error("first cycle after reset not at reset vector");

endmodule : cpu_wrapper_asserts

bind cpu_wrapper cpu_wrapper_asserts asserts_i (
   .clk    (clk),
   .reset  (reset),
   .rdy_in (rdy_in),
   .res    (res),
   .rd     (rd),
   .ab     (ab),
   .db_out (db_out)
);

/* sim/tb_cpu_wrapper.sv */
`timescale 1ns/1ps

module tb_cpu_wrapper import cpu_pkg::*; ();

   localparam logic [15:0] MARK = 16'h02FF;        // last store of every program

   logic        clk;
   logic        reset;
   logic        rdy;
   logic        halt_b;
   logic [7:0]  db_in;
   logic [7:0]  db_out;
   logic [15:0] ab;
   logic [15:0] pc_temp;
   logic        rd;
   logic [7:0]  mem [0:65535];                     // bus memory
   logic [7:0]  mdl_mem [0:65535];                 // reference model copy
   logic [15:0] wr_addr [$];                       // writes seen on the bus
   logic [7:0]  wr_data [$];
   logic [15:0] exp_addr [$];                      // writes the model predicts
   logic [7:0]  exp_data [$];
   logic [15:0] asm_pc;                            // program builder position
   logic        marker_seen;
   logic        stall_en;
   logic        rdy_exp;                           // ready as the core should see it
   integer      seed;
   int          errors;
   int          tests;
   int          stall_cnt;

   cpu_wrapper dut_i (
      .clk     (clk),
      .reset   (reset),
      .db_in   (db_in),
      .rdy     (rdy),
      .halt_b  (halt_b),
      .ab      (ab),
      .db_out  (db_out),
      .rd      (rd),
      .pc_temp (pc_temp)
   );

   assign db_in = mem[ab];                         // async read

   always #4 clk = ~clk;                           // 8 ns period

   task automatic check_val(input string name, input logic [31:0] expv,
                            input logic [31:0] actv);
      if (expv !== actv) begin
         $display("[ERROR] %s: expected %h, got %h", name, expv, actv);
         errors++;
      end
   endtask

   // both stall inputs sampled mid-cycle, reset reads as ready
   always @(negedge clk) begin
      rdy_exp <= reset | (rdy & halt_b);
   end

   // write side of the memory, one write per cycle with rd low
   always @(posedge clk) begin
      if (!rd) begin
         check_val("rdy_in", 32'd1, rdy_exp);      // never writes while stalled
         mem[ab] <= db_out;
         wr_addr.push_back(ab);
         wr_data.push_back(db_out);
         if (ab == MARK) marker_seen = 1'b1;
      end
   end

   // back-pressure, random stretches on rdy and halt_b
   always @(posedge clk) begin : stall_gen
      logic [31:0] r;
      if (!stall_en) begin
         rdy       <= 1'b1;
         halt_b    <= 1'b1;
         stall_cnt  = 0;
      end else if (stall_cnt == 0) begin
         r          = $random(seed);
         stall_cnt  = r[2:0];                      // stretch of 1 to 8 cycles
         rdy       <= r[3] | r[4];
         halt_b    <= r[5] | r[6];
      end else begin
         stall_cnt  = stall_cnt - 1;
      end
   end

   function automatic logic [7:0] rand8();
      logic [31:0] r;
      r = $random(seed);
      return r[7:0];
   endfunction

   function automatic logic [7:0] fill_byte(input logic [15:0] addr);
      return addr[15:8] ^ addr[7:0] ^ 8'h5A;       // whole address in the pattern
   endfunction

   task automatic poke(input logic [15:0] addr, input logic [7:0] b);
      mem[addr]     = b;
      mdl_mem[addr] = b;
   endtask

   task automatic put_byte(input logic [7:0] b);
      poke(asm_pc, b);
      asm_pc = asm_pc + 16'd1;
   endtask

   task automatic put_imm(input logic [7:0] op, input logic [7:0] v);
      put_byte(op);
      put_byte(v);
   endtask

   task automatic put_abs(input logic [7:0] op, input logic [15:0] addr);
      put_byte(op);
      put_byte(addr[7:0]);                         // little endian
      put_byte(addr[15:8]);
   endtask

   // reset held while memory and vector are loaded
   task automatic start_prog(input logic [15:0] start);
      @(posedge clk);
      reset    <= 1'b1;
      stall_en <= 1'b0;
      for (int i = 0; i < 65536; i++) begin
         mem[i]     = fill_byte(i[15:0]);
         mdl_mem[i] = mem[i];
      end
      poke(RESET_VEC, start[7:0]);
      poke(RESET_VEC + 16'd1, start[15:8]);
      asm_pc = start;
   endtask

   task automatic end_prog();
      put_abs(STA_ABS, MARK);
      put_abs(JMP_ABS, asm_pc);                    // spin on itself
   endtask

   // instruction-level model, stops at the marker store
   task automatic run_model();
      logic [15:0] pc;
      logic [15:0] t;
      logic [7:0]  a;
      logic [7:0]  x;
      logic [7:0]  op;
      logic [7:0]  v;
      logic [8:0]  s;
      logic        c;
      exp_addr.delete();
      exp_data.delete();
      pc = {mdl_mem[RESET_VEC + 16'd1], mdl_mem[RESET_VEC]};
      a  = 8'h00;
      x  = 8'h00;
      c  = 1'b0;
      for (int n = 0; n < 4096; n++) begin
         op = mdl_mem[pc];
         v  = mdl_mem[pc + 16'd1];
         t  = {mdl_mem[pc + 16'd2], v};            // absolute operand
         case (op)
            LDA_IMM: a = v;
            LDX_IMM: x = v;
            ADC_IMM: begin
               s = {1'b0, a} + {1'b0, v} + {8'd0, c};
               a = s[7:0];
               c = s[8];
            end
            AND_IMM: a = a & v;
            ORA_IMM: a = a | v;
            EOR_IMM: a = a ^ v;
            LDA_ABS: a = mdl_mem[t];
            STA_ABS, STX_ABS: begin
               mdl_mem[t] = (op == STX_ABS) ? x : a;
               exp_addr.push_back(t);
               exp_data.push_back(mdl_mem[t]);
               if (t == MARK) return;
            end
            INX:     x = x + 8'd1;
            CLC:     c = 1'b0;
            SEC:     c = 1'b1;
            default: ;
         endcase
         case (op)
            LDA_IMM, LDX_IMM, ADC_IMM, AND_IMM, ORA_IMM, EOR_IMM: pc = pc + 16'd2;
            LDA_ABS, STA_ABS, STX_ABS: pc = pc + 16'd3;
            JMP_ABS: pc = t;
            default: pc = pc + 16'd1;              // implied and unknown codes
         endcase
      end
   endtask

   task automatic release_reset();
      wr_addr.delete();
      wr_data.delete();
      marker_seen = 1'b0;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
   endtask

   // wait for the marker, compare all writes, print the test line
   task automatic finish_test(input string name, input int err0, input int limit);
      int n;
      n = 0;
      while (!marker_seen && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (!marker_seen) begin
         $display("%s: timeout, no write to the marker address in %0d cycles", name, limit);
         errors++;
      end
      stall_en <= 1'b0;
      check_val("write count", exp_addr.size(), wr_addr.size());
      for (int i = 0; i < exp_addr.size() && i < wr_addr.size(); i++) begin
         check_val("write address", exp_addr[i], wr_addr[i]);
         check_val("write data", exp_data[i], wr_data[i]);
      end
      tests++;
      $display("%-14s %s", name, (errors == err0) ? "ok" : "mismatch");
   endtask

   task automatic build_alu();
      logic [7:0] ops [4] = '{ADC_IMM, AND_IMM, ORA_IMM, EOR_IMM};
      for (int k = 0; k < 4; k++) begin
         put_imm(LDA_IMM, rand8());
         put_imm(ops[k], rand8());
         put_abs(STA_ABS, 16'h0310 + k);
      end
      for (int k = 0; k < 2; k++) begin
         put_byte(k ? SEC : CLC);
         put_imm(LDA_IMM, rand8());
         put_imm(ADC_IMM, rand8());
         put_abs(STA_ABS, 16'h0318 + 2 * k);
         put_imm(LDA_IMM, 8'h00);
         put_imm(ADC_IMM, 8'h00);                  // carry shows up as 0 or 1
         put_abs(STA_ABS, 16'h0319 + 2 * k);
      end
   endtask

   task automatic build_ldst();
      poke(16'h0350, rand8());
      put_abs(LDA_ABS, 16'h0350);
      put_abs(STA_ABS, 16'h0360);
      put_imm(LDX_IMM, rand8());
      put_byte(INX);
      put_byte(INX);
      put_abs(STX_ABS, 16'h0361);
      put_imm(LDX_IMM, 8'hFF);
      put_byte(INX);                               // wraps to 00
      put_abs(STX_ABS, 16'h0362);
      put_abs(STX_ABS, 16'h0350);                  // overwrite, read back below
      put_abs(LDA_ABS, 16'h0350);
      put_abs(STA_ABS, 16'h0363);
   endtask

   task automatic test_reset_seq();
      int e0;
      e0 = errors;
      start_prog(16'h0420);
      put_byte(NOP);
      put_imm(LDA_IMM, rand8());
      put_abs(STA_ABS, 16'h0300);
      end_prog();
      run_model();
      release_reset();
      @(negedge clk);
      check_val("ab", 16'hFFFC, ab);
      @(negedge clk);
      check_val("ab", 16'hFFFD, ab);
      @(negedge clk);
      check_val("ab", 16'h0420, ab);               // opcode fetch at vector
      check_val("pc_temp", 16'h0420, pc_temp);
      @(negedge clk);
      check_val("pc_temp", 16'h0421, pc_temp);
      finish_test("reset_vector", e0, 200);
   endtask

   task automatic test_alu_imm();
      int e0;
      e0 = errors;
      start_prog(16'h0500);
      build_alu();
      end_prog();
      run_model();
      release_reset();
      finish_test("alu_immediate", e0, 500);
   endtask

   task automatic test_load_store();
      int e0;
      e0 = errors;
      start_prog(16'h0600);
      build_ldst();
      end_prog();
      run_model();
      release_reset();
      finish_test("load_store", e0, 500);
   endtask

   task automatic test_jump();
      int e0;
      e0 = errors;
      start_prog(16'h0700);
      put_imm(LDA_IMM, rand8());
      put_abs(JMP_ABS, asm_pc + 16'd6);            // over the next store
      put_abs(STA_ABS, 16'h0370);
      put_abs(STA_ABS, 16'h0371);
      end_prog();
      run_model();
      release_reset();
      finish_test("jump", e0, 200);
      check_val("mem[0370]", fill_byte(16'h0370), mem[16'h0370]);
   endtask

   task automatic test_stall();
      int e0;
      e0 = errors;
      start_prog(16'h0800);
      build_alu();
      build_ldst();
      end_prog();
      run_model();
      release_reset();
      stall_en <= 1'b1;
      finish_test("stall", e0, 4000);
   endtask

   task automatic test_unknown();
      int e0;
      e0 = errors;
      start_prog(16'h0900);
      put_imm(LDA_IMM, rand8());
      put_byte(8'h02);                             // not decoded
      put_abs(STA_ABS, 16'h0380);
      put_byte(8'hFF);
      put_byte(8'h80);
      put_imm(LDX_IMM, rand8());
      put_byte(8'h00);
      put_abs(STX_ABS, 16'h0381);
      put_byte(8'hDB);
      put_imm(ADC_IMM, rand8());
      put_abs(STA_ABS, 16'h0382);
      end_prog();
      run_model();
      release_reset();
      finish_test("unknown_ops", e0, 300);
   endtask

   initial begin
      clk         = 1'b0;
      reset       = 1'b1;
      rdy         = 1'b1;
      halt_b      = 1'b1;
      stall_en    = 1'b0;
      marker_seen = 1'b0;
      stall_cnt   = 0;
      asm_pc      = 16'h0000;
      seed        = 32'h202d_82fc;
      errors      = 0;
      tests       = 0;
      test_reset_seq();
      test_alu_imm();
      test_load_store();
      test_jump();
      test_stall();
      test_unknown();
      $display("tests run %0d, errors %0d", tests, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule : tb_cpu_wrapper

/* src/cpu_alu.sv */
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
   input  alu_op_t           alu_op,               // from decoder
   input  logic [DATA_W-1:0] operand,              // held data bus byte
   input  logic [DATA_W-1:0] a,                    // accumulator
   input  logic [DATA_W-1:0] x,                    // index register
   input  logic              c_in,                 // current carry
   output logic [DATA_W-1:0] result,               // byte for write-back
   output logic              c_next,               // new carry
   output logic              z_next,               // result zero
   output logic              n_next                // result bit 7
);

   logic [DATA_W:0] sum;                           // adder with carry out

   // binary add only, no decimal mode
   assign sum = {1'b0, a} + {1'b0, operand} + {{DATA_W{1'b0}}, c_in};

   always_comb begin
      result = '0;
      c_next = c_in;                               // carry kept unless changed
      case (alu_op)
         ALU_PASS: result = operand;               // loads
         ALU_ADC: begin
            result = sum[DATA_W-1:0];
            c_next = sum[DATA_W];                  // carry out of bit 7
         end
         ALU_AND:  result = a & operand;
         ALU_OR:   result = a | operand;
         ALU_XOR:  result = a ^ operand;
         ALU_INC:  result = x + 1'b1;              // wraps at ff, carry untouched
         ALU_SEC: begin
            result = a;                            // not written back
            c_next = 1'b1;
         end
         ALU_CLC: begin
            result = a;
            c_next = 1'b0;
         end
         default:  result = '0;                    // none
      endcase
   end

   assign z_next = (result == '0);
   assign n_next = result[DATA_W-1];               // sign bit

endmodule : cpu_alu

/* src/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
   input  logic              clk,
   input  logic              reset,                // sync, active high
   input  logic              rdy_in,               // low freezes all state
   input  logic [DATA_W-1:0] db_hold,              // data bus from wrapper
   output logic [ADDR_W-1:0] ab,                   // address bus
   output logic [DATA_W-1:0] db_out,               // store data
   output logic              we,                   // write request
   output logic              res,                  // reset vector in progress
   output logic [ADDR_W-1:0] pc_temp               // next fetch address
);

   state_t            state;                       // bus cycle
   logic [ADDR_W-1:0] pc;
   logic [DATA_W-1:0] opcode;                      // instruction register
   logic [DATA_W-1:0] addr_lo;                     // operand / vector low byte
   logic [DATA_W-1:0] addr_hi;                     // operand high byte

   mode_t             mode;
   alu_op_t           alu_op;
   dest_t             dest;
   logic              is_store;
   logic              store_x;
   logic              is_jump;

   logic [DATA_W-1:0] result;
   logic              c_next;
   logic              z_next;
   logic              n_next;
   logic [DATA_W-1:0] a;
   logic [DATA_W-1:0] x;
   logic              flag_c;
   logic              wb_en;

   cpu_decode decode_i (
      .opcode   (opcode),
      .mode     (mode),
      .alu_op   (alu_op),
      .dest     (dest),
      .is_store (is_store),
      .store_x  (store_x),
      .is_jump  (is_jump)
   );

   cpu_alu alu_i (
      .alu_op  (alu_op),
      .operand (db_hold),                          // immediate or loaded byte
      .a       (a),
      .x       (x),
      .c_in    (flag_c),
      .result  (result),
      .c_next  (c_next),
      .z_next  (z_next),
      .n_next  (n_next)
   );

   cpu_regs regs_i (
      .clk    (clk),
      .reset  (reset),
      .wb_en  (wb_en),
      .dest   (dest),
      .result (result),
      .c_next (c_next),
      .z_next (z_next),
      .n_next (n_next),
      .a      (a),
      .x      (x),
      .flag_c (flag_c),
      .flag_z (),                                  // no branches use z/n
      .flag_n ()
   );

   // address select, depends on registered state only
   always_comb begin
      case (state)
         ST_VEC_LO: ab = RESET_VEC;
         ST_VEC_HI: ab = RESET_VEC + 1'b1;
         ST_MEM:    ab = {addr_hi, addr_lo};       // operand address
         default:   ab = pc;                       // fetch / operand bytes
      endcase
   end

   // write-back in the last cycle: op_lo for imp/imm, mem for loads
   assign wb_en = rdy_in & (((state == ST_OP_LO) & (mode != MODE_ABS)) |
                            ((state == ST_MEM) & ~is_store));

   assign we      = (state == ST_MEM) & is_store;  // wrapper qualifies with ready
   assign db_out  = store_x ? x : a;
   assign res     = (state == ST_VEC_LO) | (state == ST_VEC_HI);
   assign pc_temp = pc;

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= ST_VEC_LO;
         pc     <= '0;
         opcode <= NOP;                            // decodes to nothing
      end else if (rdy_in) begin
         case (state)
            ST_VEC_LO: begin
               addr_lo <= db_hold;                 // vector low
               state   <= ST_VEC_HI;
            end
            ST_VEC_HI: begin
               pc    <= {db_hold, addr_lo};        // start address
               state <= ST_FETCH;
            end
            ST_FETCH: begin
               opcode <= db_hold;
               pc     <= pc + 1'b1;
               state  <= ST_OP_LO;
            end
            ST_OP_LO: begin
               addr_lo <= db_hold;
               if (mode != MODE_IMP) pc <= pc + 1'b1;  // implied rereads, no step
               if (mode == MODE_ABS) state <= ST_OP_HI;
               else state <= ST_FETCH;
            end
            ST_OP_HI: begin
               addr_hi <= db_hold;
               if (is_jump) begin
                  pc    <= {db_hold, addr_lo};     // jmp target
                  state <= ST_FETCH;
               end else begin
                  pc    <= pc + 1'b1;
                  state <= ST_MEM;
               end
            end
            ST_MEM:  state <= ST_FETCH;            // load wb or store this cycle
            default: state <= ST_FETCH;
         endcase
      end
   end

endmodule : cpu_core

/* src/cpu_decode.sv */
`timescale 1ns/1ps

module cpu_decode import cpu_pkg::*; (
   input  logic [DATA_W-1:0] opcode,               // latched opcode byte
   output mode_t             mode,                 // addressing mode
   output alu_op_t           alu_op,               // execute operation
   output dest_t             dest,                 // write-back target
   output logic              is_store,             // memory write in last cycle
   output logic              store_x,              // store x instead of a
   output logic              is_jump               // pc load after address high
);

   always_comb begin
      // defaults give the 1-byte nop for unknown codes
      mode     = MODE_IMP;
      alu_op   = ALU_NONE;
      dest     = DEST_NONE;
      is_store = 1'b0;
      store_x  = 1'b0;
      is_jump  = 1'b0;
      case (opcode)
         LDA_IMM: begin
            mode   = MODE_IMM;
            alu_op = ALU_PASS;                     // load goes through alu for z/n
            dest   = DEST_A;
         end
         LDA_ABS: begin
            mode   = MODE_ABS;
            alu_op = ALU_PASS;
            dest   = DEST_A;
         end
         LDX_IMM: begin
            mode   = MODE_IMM;
            alu_op = ALU_PASS;
            dest   = DEST_X;
         end
         STA_ABS: begin
            mode     = MODE_ABS;
            is_store = 1'b1;                       // a on db_out
         end
         STX_ABS: begin
            mode     = MODE_ABS;
            is_store = 1'b1;
            store_x  = 1'b1;                       // x on db_out
         end
         ADC_IMM: begin
            mode   = MODE_IMM;
            alu_op = ALU_ADC;
            dest   = DEST_A;
         end
         AND_IMM: begin
            mode   = MODE_IMM;
            alu_op = ALU_AND;
            dest   = DEST_A;
         end
         ORA_IMM: begin
            mode   = MODE_IMM;
            alu_op = ALU_OR;
            dest   = DEST_A;
         end
         EOR_IMM: begin
            mode   = MODE_IMM;
            alu_op = ALU_XOR;
            dest   = DEST_A;
         end
         INX: begin
            alu_op = ALU_INC;                      // implied, result to x
            dest   = DEST_X;
         end
         CLC: begin
            alu_op = ALU_CLC;
            dest   = DEST_FLAGS;
         end
         SEC: begin
            alu_op = ALU_SEC;
            dest   = DEST_FLAGS;
         end
         JMP_ABS: begin
            mode    = MODE_ABS;
            is_jump = 1'b1;                        // ends after address high
         end
         default: ;                                // nop and unknown codes
      endcase
   end

endmodule : cpu_decode

/* src/cpu_pkg.sv */
package cpu_pkg;

   // bus widths
   localparam int ADDR_W = 16;                     // address bus
   localparam int DATA_W = 8;                      // data bus

   // first byte of the reset vector, high byte follows
   localparam logic [ADDR_W-1:0] RESET_VEC = 16'hFFFC;

   // supported opcode bytes, anything else is a 1-byte nop
   typedef enum logic [7:0] {
      LDA_IMM = 8'hA9,                             // lda #nn
      LDA_ABS = 8'hAD,                             // lda nnnn
      LDX_IMM = 8'hA2,                             // ldx #nn
      STA_ABS = 8'h8D,                             // sta nnnn
      STX_ABS = 8'h8E,                             // stx nnnn
      ADC_IMM = 8'h69,                             // adc #nn
      AND_IMM = 8'h29,                             // and #nn
      ORA_IMM = 8'h09,                             // ora #nn
      EOR_IMM = 8'h49,                             // eor #nn
      INX     = 8'hE8,                             // x + 1
      CLC     = 8'h18,                             // c = 0
      SEC     = 8'h38,                             // c = 1
      NOP     = 8'hEA,                             // no operation
      JMP_ABS = 8'h4C                              // jmp nnnn
   } op_t;

   // operation done by the execute stage
   typedef enum logic [3:0] {
      ALU_PASS = 4'd0,                             // operand straight through
      ALU_ADC  = 4'd1,                             // a + operand + c
      ALU_AND  = 4'd2,                             // a & operand
      ALU_OR   = 4'd3,                             // a | operand
      ALU_XOR  = 4'd4,                             // a ^ operand
      ALU_INC  = 4'd5,                             // x + 1
      ALU_SEC  = 4'd6,                             // carry set
      ALU_CLC  = 4'd7,                             // carry clear
      ALU_NONE = 4'd8                              // nothing computed
   } alu_op_t;

   // addressing mode, sets the cycle count
   typedef enum logic [1:0] {
      MODE_IMP = 2'd0,                             // 2 cycles, no operand
      MODE_IMM = 2'd1,                             // 2 cycles, one operand byte
      MODE_ABS = 2'd2                              // 3 or 4 cycles, two address bytes
   } mode_t;

   // write-back target
   typedef enum logic [1:0] {
      DEST_NONE  = 2'd0,
      DEST_A     = 2'd1,
      DEST_X     = 2'd2,
      DEST_FLAGS = 2'd3                            // carry only
   } dest_t;

   // bus cycle sequencer
   typedef enum logic [2:0] {
      ST_VEC_LO = 3'd0,                            // ab = fffc
      ST_VEC_HI = 3'd1,                            // ab = fffd
      ST_FETCH  = 3'd2,                            // opcode read at pc
      ST_OP_LO  = 3'd3,                            // operand / address low
      ST_OP_HI  = 3'd4,                            // address high
      ST_MEM    = 3'd5                             // data access at operand address
   } state_t;

endpackage : cpu_pkg

/* src/cpu_regs.sv */
`timescale 1ns/1ps

module cpu_regs import cpu_pkg::*; (
   input  logic              clk,
   input  logic              reset,                // sync, active high
   input  logic              wb_en,                // last cycle of an instruction
   input  dest_t             dest,                 // target register
   input  logic [DATA_W-1:0] result,               // alu result
   input  logic              c_next,
   input  logic              z_next,
   input  logic              n_next,
   output logic [DATA_W-1:0] a,                    // accumulator
   output logic [DATA_W-1:0] x,                    // index register
   output logic              flag_c,
   output logic              flag_z,
   output logic              flag_n
);

   always_ff @(posedge clk) begin
      if (reset) begin
         a      <= '0;
         x      <= '0;
         flag_c <= 1'b0;
         flag_z <= 1'b0;
         flag_n <= 1'b0;
      end else if (wb_en) begin
         case (dest)
            DEST_A: begin
               a      <= result;
               flag_c <= c_next;                   // alu keeps c for logic ops
               flag_z <= z_next;
               flag_n <= n_next;
            end
            DEST_X: begin
               x      <= result;
               flag_c <= c_next;                   // inx leaves c as it was
               flag_z <= z_next;
               flag_n <= n_next;
            end
            DEST_FLAGS: begin
               flag_c <= c_next;                   // clc / sec, z and n kept
            end
            default: ;                             // stores, jmp, nop
         endcase
      end
   end

endmodule : cpu_regs

/* src/cpu_wrapper.sv */
`timescale 1ns/1ps

module cpu_wrapper import cpu_pkg::*; (
   input  logic              clk,                  // cpu clock
   input  logic              reset,                // sync, active high
   input  logic [DATA_W-1:0] db_in,                // data from memory
   input  logic              rdy,                  // bus ready, 0 stalls
   input  logic              halt_b,               // halt, active low
   output logic [ADDR_W-1:0] ab,                   // address bus
   output logic [DATA_W-1:0] db_out,               // data to memory
   output logic              rd,                   // low on accepted write
   output logic [ADDR_W-1:0] pc_temp               // program counter view
);

   logic              rdy_in;                      // combined ready, falling edge
   logic              res;                         // vector fetch from core
   logic              we;                          // raw write request
   logic [DATA_W-1:0] db_q;                        // last data seen while ready
   logic [DATA_W-1:0] db_hold;                     // data into the core

   // both stall sources sampled mid-cycle so the next rising edge sees a clean level
   always_ff @(negedge clk) begin
      if (reset) begin
         rdy_in <= 1'b1;                           // never stalled in reset
      end else begin
         rdy_in <= rdy & halt_b;
      end
   end

   // capture uses the old ready, ab is settled by the falling edge
   always_ff @(negedge clk) begin
      if (rdy_in) db_q <= db_in;
   end

   assign db_hold = rdy_in ? db_in : db_q;         // frozen while stalled

   // write only when ready and outside vector fetch / reset
   assign rd = ~(we & rdy_in & ~res & ~reset);

   cpu_core core_i (
      .clk     (clk),
      .reset   (reset),
      .rdy_in  (rdy_in),
      .db_hold (db_hold),
      .ab      (ab),
      .db_out  (db_out),
      .we      (we),
      .res     (res),
      .pc_temp (pc_temp)
   );

endmodule : cpu_wrapper

/* verilog.f */
src/cpu_pkg.sv
src/cpu_decode.sv
src/cpu_alu.sv
src/cpu_regs.sv
src/cpu_core.sv
src/cpu_wrapper.sv
sim/cpu_wrapper_asserts.sv
sim/tb_cpu_wrapper.sv
